// ==== common/fpAccumPkg.sv ====
`default_nettype none

package fpAccumPkg;

	// Half-precision word, sign at bit 15
	typedef logic [15:0] halfT;

	typedef logic [4:0] expT;    // Biased exponent, bias 15
	typedef logic [9:0] mantT;   // Stored fraction, hidden bit implied

	// Working mantissa between adder halves
	// [15] hidden bit, [14:5] fraction, [4:0] guard, round and sticky space
	typedef logic [15:0] alignT;

	// Issue strobe to sum strobe, in clock cycles
	localparam int ADD_LATENCY = 3;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE,         // Waiting for apStart
		ISSUE_HI,     // Latched high pair goes to the adder
		WAIT_LO,      // Low partial sum in flight
		WAIT_HI,      // High partial sum in flight
		WAIT_FINAL,   // Final addition in flight
		DONE_HOLD     // Result held until apContinue
	} accumStateT;

endpackage

`default_nettype wire

// ==== fpAdd/fpAddAlign.sv ====
`default_nettype none
`timescale 1ns/1ns

module fpAddAlign
	import fpAccumPkg::*;
(
	input  wire halfT opA,
	input  wire halfT opB,
	output expT       expCommon,   // Exponent of the larger operand
	output alignT     mantMax,     // Larger mantissa, unshifted
	output alignT     mantMin,     // Smaller mantissa, aligned with sticky
	output logic      signMax,     // Result sign
	output logic      signMin
);

	expT expA, expB;
	mantT mantA, mantB;
	expT expMinor;              // Exponent of the smaller operand
	expT shiftAmt;              // Alignment distance
	logic aLarger;
	alignT fullA, fullB;
	alignT minFull;
	logic [47:0] shiftWide;     // Room for every bit shifted out

	// Field split
	assign expA = opA[14:10];
	assign expB = opB[14:10];
	assign mantA = opA[9:0];
	assign mantB = opB[9:0];

	// Raw magnitude compare orders zeros and normals correctly
	assign aLarger = (opA[14:0] >= opB[14:0]);

	// Hidden bit only for a nonzero exponent
	assign fullA = {|expA, mantA, 5'b00000};
	assign fullB = {|expB, mantB, 5'b00000};

	assign expCommon = aLarger ? expA : expB;
	assign expMinor = aLarger ? expB : expA;
	assign mantMax = aLarger ? fullA : fullB;
	assign minFull = aLarger ? fullB : fullA;
	assign signMax = aLarger ? opA[15] : opB[15];
	assign signMin = aLarger ? opB[15] : opA[15];

	// Never negative since expCommon is the larger exponent
	assign shiftAmt = expCommon - expMinor;

	// Up to 30 places, lowest set bit of minFull never drops off the bottom
	assign shiftWide = {minFull, 32'd0} >> shiftAmt;

	// Everything below the kept window folds into bit 0
	assign mantMin = {shiftWide[47:33], |shiftWide[32:0]};

endmodule

`default_nettype wire

// ==== fpAdd/fpAddNormRound.sv ====
`default_nettype none
`timescale 1ns/1ns

module fpAddNormRound
	import fpAccumPkg::*;
(
	input  wire expT   expCommon,
	input  wire alignT mantMax,
	input  wire alignT mantMin,
	input  wire        signMax,
	input  wire        signMin,
	output halfT       sum
);

	logic effSub;              // Signs differ, so magnitudes subtract
	logic [16:0] rawSum;       // One carry bit above the hidden bit
	logic [4:0] lzc;           // Distance of leading one below bit 16
	logic [16:0] normSum;      // Leading one at bit 16
	logic [5:0] expNorm;       // One spare bit for the adjust
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [10:0] mantRnd;      // Fraction plus rounding carry
	expT expOut;
	mantT mantOut;
	logic zeroSum;

	assign effSub = signMax ^ signMin;

	// mantMax >= mantMin, so subtraction never wraps
	assign rawSum = effSub ? ({1'b0, mantMax} - {1'b0, mantMin})
		: ({1'b0, mantMax} + {1'b0, mantMin});

	assign zeroSum = (rawSum == 17'd0);

	// Leading one search, highest set bit wins
	always_comb begin : leadOne
		lzc = 5'd16;   // Only seen for a zero sum
		for (int i = 0; i <= 16; i++) begin
			if (rawSum[i]) begin
				lzc = 5'(16 - i);
			end
		end
	end

	assign normSum = rawSum << lzc;

	// Carry out gives +1, each cancelled bit gives -1
	assign expNorm = {1'b0, expCommon} + 6'd1 - {1'b0, lzc};

	// Bit 5 is first below the lsb
	assign guardBit = normSum[5];
	assign stickyBit = |normSum[4:0];

	// Nearest even, ties go to an even lsb
	assign roundUp = guardBit & (stickyBit | normSum[6]);

	assign mantRnd = {1'b0, normSum[15:6]} + 11'(roundUp);

	// All-ones fraction rolls over to zero with next exponent
	assign expOut = expNorm[4:0] + expT'(mantRnd[10]);
	assign mantOut = mantRnd[9:0];

	// Exact cancellation always gives +0
	assign sum = zeroSum ? 16'h0000 : {signMax, expOut, mantOut};

endmodule

`default_nettype wire

// ==== fpAdd/fpAdder.sv ====
`default_nettype none
`timescale 1ns/1ns

module fpAdder
	import fpAccumPkg::*;
(
	input  wire       ap_clk,
	input  wire       ap_rst,
	input  wire halfT addA,
	input  wire halfT addB,
	input  wire       addIssue,
	output halfT      addSum,
	output logic      addSumVld
);

	halfT aQ, bQ;                      // Input stage
	expT expAl, expQ;                  // Align stage
	alignT mantMaxAl, mantMaxQ;
	alignT mantMinAl, mantMinQ;
	logic signMaxAl, signMaxQ;
	logic signMinAl, signMinQ;
	halfT sumNr, sumQ;                 // Output stage
	logic [ADD_LATENCY-1:0] vldPipe;   // One valid per stage

	fpAddAlign fpAddAlign_i (
		.opA       (aQ),
		.opB       (bQ),
		.expCommon (expAl),
		.mantMax   (mantMaxAl),
		.mantMin   (mantMinAl),
		.signMax   (signMaxAl),
		.signMin   (signMinAl)
	);

	fpAddNormRound fpAddNormRound_i (
		.expCommon (expQ),
		.mantMax   (mantMaxQ),
		.mantMin   (mantMinQ),
		.signMax   (signMaxQ),
		.signMin   (signMinQ),
		.sum       (sumNr)
	);

	// Data stages run freely, a new pair every cycle
	always_ff @(posedge ap_clk) begin
		aQ <= addA;
		bQ <= addB;
		expQ <= expAl;
		mantMaxQ <= mantMaxAl;
		mantMinQ <= mantMinAl;
		signMaxQ <= signMaxAl;
		signMinQ <= signMinAl;
		sumQ <= sumNr;
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			vldPipe <= '0;
		end else begin
			vldPipe <= {vldPipe[ADD_LATENCY-2:0], addIssue};   // Shift with the data
		end
	end

	assign addSum = sumQ;
	assign addSumVld = vldPipe[ADD_LATENCY-1];

endmodule

`default_nettype wire

// ==== rtl/accumSeq.sv ====
`default_nettype none
`timescale 1ns/1ns

module accumSeq
	import fpAccumPkg::*;
(
	input  wire       ap_clk,
	input  wire       ap_rst,
	input  wire       apStart,
	input  wire       apContinue,
	input  wire halfT accumIn0,
	input  wire halfT accumIn1,
	input  wire halfT accumIn2,
	input  wire halfT accumIn3,
	output logic      apDone,
	output logic      apIdle,
	output logic      apReady,
	output halfT      accumOut,
	output logic      accumOutVld,
	output halfT      addA,
	output halfT      addB,
	output logic      addIssue,
	input  wire halfT addSum,
	input  wire       addSumVld
);

	accumStateT state, stateNext;
	halfT in2Q, in3Q;      // High pair, taken at start
	halfT partialLo;       // in0 + in1
	halfT resultQ;         // Held result
	logic startAcc;        // Start accepted this cycle
	logic finalVld;        // Final sum on addSum
	logic doneHold;

	assign startAcc = (state == IDLE) && apStart;
	assign finalVld = (state == WAIT_FINAL) && addSumVld;
	assign doneHold = (state == DONE_HOLD);

	always_comb begin
		stateNext = state;
		case (state)
			IDLE: begin
				if (apStart) begin
					stateNext = ISSUE_HI;
				end
			end
			ISSUE_HI: stateNext = WAIT_LO;
			WAIT_LO: begin
				if (addSumVld) begin
					stateNext = WAIT_HI;   // Low partial captured
				end
			end
			WAIT_HI: begin
				if (addSumVld) begin
					stateNext = WAIT_FINAL;   // Final pair issued
				end
			end
			WAIT_FINAL: begin
				if (addSumVld) begin
					stateNext = apContinue ? IDLE : DONE_HOLD;
				end
			end
			DONE_HOLD: begin
				if (apContinue) begin
					stateNext = IDLE;
				end
			end
			default: stateNext = IDLE;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= IDLE;
			resultQ <= '0;
		end else begin
			state <= stateNext;
			if (finalVld) begin
				resultQ <= addSum;
			end
		end
	end

	always_ff @(posedge ap_clk) begin
		if (startAcc) begin
			in2Q <= accumIn2;
			in3Q <= accumIn3;
		end
		if ((state == WAIT_LO) && addSumVld) begin
			partialLo <= addSum;
		end
	end

	// Operand select, one pair per state
	always_comb begin
		case (state)
			IDLE: begin
				addA = accumIn0;
				addB = accumIn1;
			end
			ISSUE_HI: begin
				addA = in2Q;
				addB = in3Q;
			end
			default: begin
				addA = partialLo;   // Pairs with high partial as it arrives
				addB = addSum;
			end
		endcase
	end

	assign addIssue = startAcc || (state == ISSUE_HI) || ((state == WAIT_HI) && addSumVld);

	// Block control outputs
	assign accumOut = finalVld ? addSum : resultQ;
	assign accumOutVld = finalVld;
	assign apReady = finalVld;
	assign apDone = finalVld || doneHold;
	assign apIdle = (state == IDLE) && !apStart;

endmodule

`default_nettype wire

// ==== rtl/accumTop.sv ====
`default_nettype none
`timescale 1ns/1ns

module accumTop
	import fpAccumPkg::*;
(
	input  wire       ap_clk,
	input  wire       ap_rst,
	input  wire       apStart,
	input  wire       apContinue,
	input  wire halfT accumIn0,
	input  wire halfT accumIn1,
	input  wire halfT accumIn2,
	input  wire halfT accumIn3,
	output logic      apDone,
	output logic      apIdle,
	output logic      apReady,
	output halfT      accumOut,
	output logic      accumOutVld
);

	halfT addA, addB;     // Sequencer to adder
	logic addIssue;
	halfT addSum;         // Adder back to sequencer
	logic addSumVld;

	accumSeq accumSeq_i (
		.ap_clk      (ap_clk),
		.ap_rst      (ap_rst),
		.apStart     (apStart),
		.apContinue  (apContinue),
		.accumIn0    (accumIn0),
		.accumIn1    (accumIn1),
		.accumIn2    (accumIn2),
		.accumIn3    (accumIn3),
		.apDone      (apDone),
		.apIdle      (apIdle),
		.apReady     (apReady),
		.accumOut    (accumOut),
		.accumOutVld (accumOutVld),
		.addA        (addA),
		.addB        (addB),
		.addIssue    (addIssue),
		.addSum      (addSum),
		.addSumVld   (addSumVld)
	);

	// Shared by all three additions
	fpAdder fpAdder_i (
		.ap_clk    (ap_clk),
		.ap_rst    (ap_rst),
		.addA      (addA),
		.addB      (addB),
		.addIssue  (addIssue),
		.addSum    (addSum),
		.addSumVld (addSumVld)
	);

endmodule

`default_nettype wire

// ==== verif/tbClock.sv ====
`default_nettype none
`timescale 1ns/1ns

module tbClock (
	output logic ap_clk,
	output logic ap_rst
);

	localparam int PERIOD = 10;       // ns
	localparam int RST_CYCLES = 3;

	initial begin
		ap_clk = 1'b0;
		forever #(PERIOD / 2) ap_clk = ~ap_clk;
	end

	// Reset released just after the third edge
	initial begin
		ap_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge ap_clk);
		#1 ap_rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/accumTop_chk.sv ====
`default_nettype none
`timescale 1ns/1ns

module accumTopChk
	import fpAccumPkg::*;
(
	input wire             ap_clk,
	input wire             ap_rst,
	input wire             apStart,
	input wire             apReady,
	input wire             apDone,
	input wire             accumOutVld,
	input wire             addIssue,
	input wire             addSumVld,
	input wire accumStateT seqState    // Sequencer FSM state
);

	readyWithVld: assert property (@(posedge ap_clk) disable iff (ap_rst)
		apReady |-> accumOutVld)
		else $error("apReady high without accumOutVld");

	// Done only comes up together with the result strobe
	doneRise: assert property (@(posedge ap_clk) disable iff (ap_rst)
		$rose(apDone) |-> accumOutVld)
		else $error("apDone rose without accumOutVld");

	vldOneCycle: assert property (@(posedge ap_clk) disable iff (ap_rst)
		accumOutVld |=> !accumOutVld)
		else $error("accumOutVld longer than one cycle");

	// In IDLE only the accepted start issues a pair, high pair follows
	idleIssue: assert property (@(posedge ap_clk) disable iff (ap_rst)
		((seqState == IDLE) && addIssue) |-> apStart ##1 (seqState == ISSUE_HI))
		else $error("addIssue in IDLE without an accepted start");

	sumLatency: assert property (@(posedge ap_clk) disable iff (ap_rst)
		addIssue |-> ##ADD_LATENCY addSumVld)
		else $error("addSumVld missing ADD_LATENCY cycles after addIssue");

endmodule

`default_nettype wire

// ==== verif/accumTb.sv ====
`default_nettype none
`timescale 1ns/1ns

module accumTb
	import fpAccumPkg::*;
();

	localparam int RUN_CYCLES = 2 * ADD_LATENCY + 1;   // Accepting edge to final sum
	localparam int VLD_WAIT_MAX = 4 * RUN_CYCLES;
	localparam int NUM_RUNS = 21;                     // Runs over all tests
	localparam int TIMEOUT_CYCLES = 40 * NUM_RUNS;

	logic ap_clk, ap_rst;
	logic apStart, apContinue;
	halfT accumIn0, accumIn1, accumIn2, accumIn3;
	logic apDone, apIdle, apReady, accumOutVld;
	halfT accumOut;
	integer seed = 80;
	int errCount = 0;

	tbClock tbClock_i (.ap_clk(ap_clk), .ap_rst(ap_rst));

	accumTop accumTop_i (
		.ap_clk(ap_clk), .ap_rst(ap_rst), .apStart(apStart), .apContinue(apContinue),
		.accumIn0(accumIn0), .accumIn1(accumIn1), .accumIn2(accumIn2), .accumIn3(accumIn3),
		.apDone(apDone), .apIdle(apIdle), .apReady(apReady),
		.accumOut(accumOut), .accumOutVld(accumOutVld)
	);

	bind accumTop accumTopChk accumTopChk_i (
		.ap_clk(ap_clk), .ap_rst(ap_rst), .apStart(apStart), .apReady(apReady),
		.apDone(apDone), .accumOutVld(accumOutVld), .addIssue(addIssue),
		.addSumVld(addSumVld), .seqState(accumSeq_i.state)
	);

	task automatic endInFailure(input string why);
		$display("%s", why);
		$display("TB FAILED");
		errCount++;
		$fatal(1, "Stopped at first error");
	endtask

	task automatic checkHalf(input string name, input halfT got, input halfT expVal);
		if (got !== expVal) begin
			endInFailure($sformatf("Fail at %0t ns: %s is %h, expected %h",
				$time, name, got, expVal));
		end
	endtask

	task automatic checkCycles(input string name, input int got, input int expVal);
		if (got != expVal) begin
			endInFailure($sformatf("Fail at %0t ns: %s is %0d, expected %0d",
				$time, name, got, expVal));
		end
	endtask

	task automatic checkLevel(input string name, input logic got, input logic expVal);
		if (got !== expVal) begin
			endInFailure($sformatf("Fail at %0t ns: %s is %b, expected %b",
				$time, name, got, expVal));
		end
	endtask

	function automatic real pow2(input int n);
		real p;
		p = 1.0;
		if (n >= 0) begin
			repeat (n) p = p * 2.0;
		end else begin
			repeat (-n) p = p / 2.0;
		end
		return p;
	endfunction

	// Zero or normal only
	function automatic real halfToReal(input halfT h);
		real mag;
		if (h[14:10] == 5'd0) begin
			return 0.0;
		end
		mag = real'(1024 + int'(h[9:0])) * pow2(int'(h[14:10]) - 25);
		return h[15] ? -mag : mag;
	endfunction

	// Round to nearest even, exact zero gives +0
	function automatic halfT realToHalf(input real r);
		real mag, scaled, frac;
		int e, m;
		logic s;
		if (r == 0.0) begin
			return 16'h0000;
		end
		s = (r < 0.0);
		mag = s ? -r : r;
		e = 0;
		while (mag >= pow2(e + 1)) e++;
		while (mag < pow2(e)) e--;
		scaled = mag / pow2(e - 10);   // 1024 up to below 2048
		m = $rtoi(scaled);
		frac = scaled - m;
		if ((frac > 0.5) || ((frac == 0.5) && ((m % 2) == 1))) begin
			m++;
		end
		if (m == 2048) begin   // Rounding carried into the exponent
			m = 1024;
			e++;
		end
		return {s, 5'(e + 15), 10'(m)};
	endfunction

	// (in0 + in1) + (in2 + in3), each partial rounded to half
	function automatic halfT modelSum(input halfT a0, input halfT a1,
		input halfT a2, input halfT a3);
		halfT lo, hi;
		lo = realToHalf(halfToReal(a0) + halfToReal(a1));
		hi = realToHalf(halfToReal(a2) + halfToReal(a3));
		return realToHalf(halfToReal(lo) + halfToReal(hi));
	endfunction

	// Exponents 12 to 18 keep every partial and final sum normal
	task automatic randomNormal(output halfT h);
		int rndA, rndB;
		rndA = $random(seed);
		rndB = $random(seed);
		h = {rndA[20], 5'(12 + ($unsigned(rndB) % 7)), rndA[9:0]};
	endtask

	task automatic runSum(input halfT a0, input halfT a1, input halfT a2, input halfT a3);
		halfT expVal;
		int cycles;
		logic seen;
		expVal = modelSum(a0, a1, a2, a3);
		@(posedge ap_clk);
		#1;
		checkLevel("apIdle", apIdle, 1'b1);
		apStart = 1'b1;
		accumIn0 = a0;
		accumIn1 = a1;
		accumIn2 = a2;
		accumIn3 = a3;
		@(posedge ap_clk);   // Accepting edge
		#1 apStart = 1'b0;
		cycles = 0;
		seen = 1'b0;
		while (!seen && (cycles < VLD_WAIT_MAX)) begin
			@(negedge ap_clk);
			cycles++;
			seen = (accumOutVld === 1'b1);
		end
		if (!seen) begin
			endInFailure("accumOutVld never came after a start");
		end
		checkCycles("accumOutVld latency", cycles, RUN_CYCLES);
		checkHalf("accumOut", accumOut, expVal);
		checkLevel("apReady", apReady, 1'b1);
		checkLevel("apDone", apDone, 1'b1);
		@(negedge ap_clk);   // One cycle later, result held
		checkLevel("accumOutVld", accumOutVld, 1'b0);
		checkLevel("apReady", apReady, 1'b0);
		checkLevel("apDone", apDone, !apContinue);
		checkLevel("apIdle", apIdle, apContinue);
		checkHalf("accumOut held", accumOut, expVal);
	endtask

	task automatic testReset();
		@(negedge ap_clk);
		checkLevel("apIdle", apIdle, 1'b1);
		checkLevel("apDone", apDone, 1'b0);
		checkLevel("apReady", apReady, 1'b0);
		checkLevel("accumOutVld", accumOutVld, 1'b0);
		checkHalf("accumOut", accumOut, 16'h0000);
	endtask

	task automatic testExact();
		runSum(16'h3C00, 16'h4000, 16'h3800, 16'h3400);   // 1 + 2 + 0.5 + 0.25
		checkHalf("accumOut", accumOut, 16'h4380);
		runSum(16'h3E00, 16'h3400, 16'h3000, 16'h4400);
	endtask

	task automatic testCancel();
		runSum(16'h4300, 16'hC300, 16'h3E00, 16'hBD00);
		runSum(16'h4000, 16'hBC00, 16'hB800, 16'hB800);   // Total exactly zero
		checkHalf("accumOut", accumOut, 16'h0000);
		runSum(16'h3C00, 16'hBBFF, 16'hC500, 16'h4500);
	endtask

	task automatic testRounding();
		halfT r0, r1, r2, r3;
		runSum(16'h6400, 16'h3800, 16'h6401, 16'h3800);   // Ties to even both ways
		runSum(16'h6400, 16'h8400, 16'h3C00, 16'h1000);   // Sticky on subtract
		runSum(16'h3C01, 16'h1000, 16'h3C00, 16'h3C00);
		runSum(16'h4BFF, 16'h4BFF, 16'hC7FF, 16'h3555);
		repeat (10) begin
			randomNormal(r0);
			randomNormal(r1);
			randomNormal(r2);
			randomNormal(r3);
			runSum(r0, r1, r2, r3);
		end
	endtask

	task automatic testHold();
		@(posedge ap_clk);
		#1 apContinue = 1'b0;
		runSum(16'h4200, 16'h3C00, 16'h3800, 16'h3800);
		@(posedge ap_clk);
		#1;
		apStart = 1'b1;   // Must be ignored while done is held
		accumIn0 = 16'h4400;
		accumIn1 = 16'h4400;
		accumIn2 = 16'h4400;
		accumIn3 = 16'h4400;
		repeat (3) begin
			@(negedge ap_clk);
			checkLevel("apDone", apDone, 1'b1);
			checkLevel("apReady", apReady, 1'b0);
			checkLevel("accumOutVld", accumOutVld, 1'b0);
			checkHalf("accumOut held", accumOut, 16'h4500);
		end
		@(posedge ap_clk);
		#1;
		apStart = 1'b0;
		apContinue = 1'b1;
		@(negedge ap_clk);
		checkLevel("apDone", apDone, 1'b1);   // Continue not yet sampled
		@(negedge ap_clk);
		checkLevel("apDone", apDone, 1'b0);
		checkLevel("apIdle", apIdle, 1'b1);
		checkHalf("accumOut held", accumOut, 16'h4500);
		runSum(16'h3C00, 16'h3C00, 16'h3C00, 16'h3C00);
	endtask

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge ap_clk);
		endInFailure("Timeout, the tests did not finish in time");
	end

	initial begin
		apStart = 1'b0;
		apContinue = 1'b1;
		accumIn0 = '0;
		accumIn1 = '0;
		accumIn2 = '0;
		accumIn3 = '0;
		@(negedge ap_rst);
		testReset();
		testExact();
		testCancel();
		testRounding();
		testHold();
		if (errCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/fpAccumPkg.sv
fpAdd/fpAddAlign.sv
fpAdd/fpAddNormRound.sv
fpAdd/fpAdder.sv
rtl/accumSeq.sv
rtl/accumTop.sv
verif/tbClock.sv
verif/accumTop_chk.sv
verif/accumTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
SIM_TOP   ?= accumTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(SIM_TOP) --Mdir $(BUILD_DIR)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
